//--- bench/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;

    localparam int REC_WORDS = 10;
    localparam int MAX_RECS  = 64;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        branch_pred;
    logic [31:0] pred_target;
    logic        pc_select;
    logic [31:0] pc_target;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_wdata;
    logic [3:0]  st_wsel;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // Word 0 is the record count, then ten words per record.
    logic [31:0] data_mem [0:REC_WORDS*MAX_RECS];
    int          num_recs;
    int          err_count;
    bit          loaded;

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    rv_exec_top u_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_flush       (flush),
        .i_valid       (valid),
        .i_instr       (instr),
        .i_pc          (pc),
        .i_branch_pred (branch_pred),
        .i_pred_target (pred_target),
        .o_pc_select   (pc_select),
        .o_pc_target   (pc_target),
        .o_st_valid    (st_valid),
        .o_st_addr     (st_addr),
        .o_st_wdata    (st_wdata),
        .o_st_wsel     (st_wsel),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    function automatic logic [31:0] field(int idx, int w);
        return data_mem[1 + idx * REC_WORDS + w];
    endfunction

    // Flags of a record, zero outside the record range.
    function automatic logic [31:0] flags_of(int idx);
        if ((idx >= 0) && (idx < num_recs))
            return field(idx, 2);
        else
            return '0;
    endfunction

    task automatic report_mismatch(string name, string what, logic [31:0] exp,
                                   logic [31:0] act);
        $display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
        err_count++;
    endtask

    task automatic check_exec(int idx);
        logic [31:0] flags;
        string       name;
        flags = flags_of(idx);
        name  = $sformatf("rec%0d", idx);
        if (flags[12])
        begin
            if (pc_select !== 1'b1)
                report_mismatch(name, "pc_select", 32'd1, 32'(pc_select));
            if (pc_target !== field(idx, 6))
                report_mismatch(name, "pc_target", field(idx, 6), pc_target);
        end
        else if (pc_select !== 1'b0)
        begin
            $display("Unexpected redirect to %h after %s", pc_target, name);
            err_count++;
        end
        if (flags[16])
        begin
            if (st_valid !== 1'b1)
                report_mismatch(name, "st_valid", 32'd1, 32'(st_valid));
            if (st_addr !== field(idx, 7))
                report_mismatch(name, "st_addr", field(idx, 7), st_addr);
            if (st_wdata !== field(idx, 8))
                report_mismatch(name, "st_wdata", field(idx, 8), st_wdata);
            if (32'(st_wsel) !== field(idx, 9))
                report_mismatch(name, "st_wsel", field(idx, 9), 32'(st_wsel));
        end
        else if (st_valid !== 1'b0)
        begin
            $display("Unexpected store to %h after %s", st_addr, name);
            err_count++;
        end
    endtask

    task automatic check_retire(int idx);
        logic [31:0] flags;
        string       name;
        flags = flags_of(idx);
        name  = $sformatf("rec%0d", idx);
        if (flags[8])
        begin
            if (wb_valid !== 1'b1)
                report_mismatch(name, "wb_valid", 32'd1, 32'(wb_valid));
            if (32'(wb_rd) !== field(idx, 4))
                report_mismatch(name, "wb_rd", field(idx, 4), 32'(wb_rd));
            if (wb_data !== field(idx, 5))
                report_mismatch(name, "wb_data", field(idx, 5), wb_data);
        end
        else if (wb_valid !== 1'b0)
        begin
            $display("Unexpected retire of x%0d after %s", wb_rd, name);
            err_count++;
        end
    endtask

    task automatic drive_record(int idx);
        logic [31:0] flags;
        flags = flags_of(idx);
        if (idx < num_recs)
        begin
            valid       = 1'b1;
            instr       = field(idx, 0);
            pc          = field(idx, 1);
            branch_pred = flags[0];
            pred_target = field(idx, 3);
            flush       = flags[4];
        end
        else
        begin
            valid       = 1'b0;
            instr       = '0;
            branch_pred = 1'b0;
            flush       = 1'b0;
        end
    endtask

    initial
    begin
        flush       = 1'b0;
        valid       = 1'b0;
        instr       = '0;
        pc          = '0;
        branch_pred = 1'b0;
        pred_target = '0;
        err_count   = 0;
        $readmemh("bench/rv_exec_testdata.hex", data_mem);
        num_recs = int'(data_mem[0]);
        if ((num_recs < 1) || (num_recs > MAX_RECS))
        begin
            $display("Data file holds a bad record count %0d", num_recs);
            err_count++;
            num_recs = 0;
        end
        loaded = 1'b1;

        // Outputs stay quiet while in reset.
        @(negedge clk);
        while (rst_n !== 1'b1)
        begin
            if ((pc_select !== 1'b0) || (st_valid !== 1'b0) || (wb_valid !== 1'b0))
            begin
                $display("Outputs active during reset");
                err_count++;
            end
            @(negedge clk);
        end

        for (int c = 0; c < num_recs + 2; c++)
        begin
            if (c > 0)
                @(negedge clk);
            check_exec(c - 1);
            check_retire(c - 2);
            drive_record(c);
        end

        $display("Records %0d, errors %0d", num_recs, err_count);
        if (err_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        wait (loaded);
        #((num_recs + 20) * 20);
        $display("Watchdog expired before all records were checked");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- bench/rv_exec_testdata.hex
// instr pc flags pred_target exp_rd exp_wb_data exp_redirect_target exp_st_addr exp_st_data exp_wsel
// flags: bit0 predict, bit4 flush, bit8 retire, bit12 redirect, bit16 store
0000002a
00500093 00000100 00000100 00000000 00000001 00000005 00000000 00000000 00000000 00000000
ffd00113 00000104 00000100 00000000 00000002 fffffffd 00000000 00000000 00000000 00000000
123451b7 00000108 00000100 00000000 00000003 12345000 00000000 00000000 00000000 00000000
00001217 0000010c 00000100 00000000 00000004 0000110c 00000000 00000000 00000000 00000000
00708013 00000110 00000100 00000000 00000000 0000000c 00000000 00000000 00000000 00000000
001002b3 00000114 00000100 00000000 00000005 00000005 00000000 00000000 00000000 00000000
40228333 00000118 00000100 00000000 00000006 00000008 00000000 00000000 00000000 00000000
003343b3 0000011c 00000100 00000000 00000007 12345008 00000000 00000000 00000000 00000000
0023e433 00000120 00000100 00000000 00000008 fffffffd 00000000 00000000 00000000 00000000
0ff3f493 00000124 00000100 00000000 00000009 00000008 00000000 00000000 00000000 00000000
00409513 00000128 00000100 00000000 0000000a 00000050 00000000 00000000 00000000 00000000
00415593 0000012c 00000100 00000000 0000000b 0fffffff 00000000 00000000 00000000 00000000
40115613 00000130 00000100 00000000 0000000c fffffffe 00000000 00000000 00000000 00000000
009096b3 00000134 00000100 00000000 0000000d 00000500 00000000 00000000 00000000 00000000
40115733 00000138 00000100 00000000 0000000e ffffffff 00000000 00000000 00000000 00000000
001157b3 0000013c 00000100 00000000 0000000f 07ffffff 00000000 00000000 00000000 00000000
00112833 00000140 00000100 00000000 00000010 00000001 00000000 00000000 00000000 00000000
001138b3 00000144 00000100 00000000 00000011 00000000 00000000 00000000 00000000 00000000
fff12913 00000148 00000100 00000000 00000012 00000001 00000000 00000000 00000000 00000000
fff0b993 0000014c 00000100 00000000 00000013 00000001 00000000 00000000 00000000 00000000
00508863 00000150 00001000 00000000 00000000 00000000 00000160 00000000 00000000 00000000
00509863 00000154 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
fe114ce3 00000158 00001000 00000000 00000000 00000000 00000150 00000000 00000000 00000000
00115863 0000015c 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00116863 00000160 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
fe117ce3 00000164 00001000 00000000 00000000 00000000 0000015c 00000000 00000000 00000000
00508863 00000168 00000001 00000178 00000000 00000000 00000000 00000000 00000000 00000000
00509863 0000016c 00001001 0000017c 00000000 00000000 00000170 00000000 00000000 00000000
02000a6f 00000170 00001100 00000000 00000014 00000174 00000190 00000000 00000000 00000000
00308ae7 00000174 00001100 00000000 00000015 00000178 00000008 00000000 00000000 00000000
02000b6f 00000178 00000101 00000198 00000016 0000017c 00000000 00000000 00000000 00000000
00718023 0000017c 00010000 00000000 00000000 00000000 00000000 12345000 08080808 00000001
007180a3 00000180 00010000 00000000 00000000 00000000 00000000 12345001 08080808 00000002
00718123 00000184 00010000 00000000 00000000 00000000 00000000 12345002 08080808 00000004
007181a3 00000188 00010000 00000000 00000000 00000000 00000000 12345003 08080808 00000008
00719023 0000018c 00010000 00000000 00000000 00000000 00000000 12345000 50085008 00000003
00719123 00000190 00010000 00000000 00000000 00000000 00000000 12345002 50085008 0000000c
0071a223 00000194 00010000 00000000 00000000 00000000 00000000 12345004 12345008 0000000f
01100c13 00000198 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0181a423 0000019c 00000010 00000000 00000000 00000000 00000000 00000000 00000000 00000000
001c0c93 000001a0 00000100 00000000 00000019 00000001 00000000 00000000 00000000 00000000
0191a023 000001a4 00010000 00000000 00000000 00000000 00000000 12345000 00000001 0000000f

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release away from the rising edge.
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu #(
    parameter int IADDR_SPACE_BITS  = 32,
    parameter bit BRANCH_PREDICTION = 1'b1
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    rv_issue_if.dst                       i_issue,
    output logic                          o_pc_select,
    output logic [IADDR_SPACE_BITS-1:0]   o_pc_target,
    output logic                          o_st_valid,
    output rv_exec_pkg::xlen_t            o_st_addr,
    output rv_exec_pkg::xlen_t            o_st_wdata,
    output logic [3:0]                    o_st_wsel,
    rv_retire_if.src                      o_retire
);

    logic                          valid;
    rv_exec_pkg::xlen_t            op1;
    rv_exec_pkg::xlen_t            op2;
    rv_exec_pkg::xlen_t            reg_data2;
    rv_exec_pkg::alu_ctrl_t        ctrl;
    rv_exec_pkg::alu_res_t         res;
    rv_exec_pkg::op_class_e        op_class;
    rv_exec_pkg::reg_idx_t         rd;
    logic [IADDR_SPACE_BITS-1:0]   pc;
    logic [IADDR_SPACE_BITS-1:0]   pc_next;
    logic [IADDR_SPACE_BITS-1:0]   target;
    logic                          branch_pred;
    logic [IADDR_SPACE_BITS-1:0]   pred_target;
    rv_exec_pkg::funct3_t          funct3;

    logic                          op_b_sel;
    logic [32:0]                   add;
    logic                          overflow;
    logic                          eq;
    logic                          lts;
    logic                          ltu;
    logic                          cmp_result;
    rv_exec_pkg::xlen_t            shl;
    rv_exec_pkg::xlen_t            shr;
    rv_exec_pkg::xlen_t            arith_result;
    rv_exec_pkg::xlen_t            bits_result;
    rv_exec_pkg::xlen_t            shift_result;
    logic                          is_jump;
    logic                          is_branch;
    logic                          is_store;
    logic                          pred_ok;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            valid <= 1'b0;
        else
            valid <= i_issue.valid && !i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        op1         <= i_issue.op1;
        op2         <= i_issue.op2;
        reg_data2   <= i_issue.reg_data2;
        ctrl        <= i_issue.ctrl;
        res         <= i_issue.res;
        op_class    <= i_issue.op_class;
        rd          <= i_issue.rd;
        pc          <= i_issue.pc;
        pc_next     <= i_issue.pc_next;
        target      <= i_issue.target;
        branch_pred <= i_issue.branch_pred;
        pred_target <= i_issue.pred_target;
        funct3      <= i_issue.funct3;
    end

    // One adder serves add, sub and compares.
    assign op_b_sel = ctrl.arith_sub | res.cmp;
    assign add      = {1'b0, op1} + {1'b0, op_b_sel ? ~op2 : op2} + 33'(op_b_sel);
    assign overflow = (op1[31] ^ op2[31]) & (op1[31] ^ add[31]);

    assign eq         = (op1 == op2);
    assign lts        = add[31] ^ overflow;
    assign ltu        = !add[32];
    assign cmp_result = ctrl.cmp_inversed ^
                        ((ctrl.cmp_eq & eq) | (ctrl.cmp_lts & lts) | (ctrl.cmp_ltu & ltu));

    assign shl = op1 << op2[4:0];
    assign shr = 32'($signed({ctrl.shift_arithmetical & op1[31], op1}) >>> op2[4:0]);

    assign arith_result = {32{ctrl.arith_add | ctrl.arith_sub}} & add[31:0];
    assign bits_result  = ({32{ctrl.bits_xor}} & (op1 ^ op2)) |
                          ({32{ctrl.bits_or}}  & (op1 | op2)) |
                          ({32{ctrl.bits_and}} & (op1 & op2));
    assign shift_result = ({32{ctrl.arith_shl}} & shl) | ({32{ctrl.arith_shr}} & shr);

    assign is_jump   = (op_class == rv_exec_pkg::op_jal) || (op_class == rv_exec_pkg::op_jalr);
    assign is_branch = (op_class == rv_exec_pkg::op_branch);
    assign is_store  = (op_class == rv_exec_pkg::op_store);

    // Fetch already followed a prediction that matches the target.
    assign pred_ok     = BRANCH_PREDICTION && branch_pred && (pred_target == target);
    assign o_pc_select = valid && ((is_jump || (is_branch && cmp_result)) ^ pred_ok);
    assign o_pc_target = pred_ok ? pc_next : target;

    assign o_st_valid = valid && is_store;
    assign o_st_addr  = add[31:0];

    always_comb
    begin
        case (funct3[1:0])
            2'b00:
            begin
                o_st_wdata = {4{reg_data2[7:0]}};
                o_st_wsel  = 4'b0001 << add[1:0];
            end
            2'b01:
            begin
                o_st_wdata = {2{reg_data2[15:0]}};
                o_st_wsel  = add[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_st_wdata = reg_data2;
                o_st_wsel  = 4'b1111;
            end
        endcase
    end

    // Branches and stores write no register.
    assign o_retire.valid  = valid && !is_branch && !is_store;
    assign o_retire.rd     = rd;
    assign o_retire.result = is_jump   ? rv_exec_pkg::xlen_t'(pc_next) :
                             res.cmp   ? {31'b0, cmp_result} :
                             res.bits  ? bits_result :
                             res.shift ? shift_result :
                             res.arith ? arith_result : 32'(pc);

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode #(
    parameter int IADDR_SPACE_BITS = 32
) (
    input  logic                          i_valid,
    input  rv_exec_pkg::xlen_t            i_instr,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pc,
    input  logic                          i_branch_pred,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pred_target,
    output rv_exec_pkg::reg_idx_t         o_rs1,
    output rv_exec_pkg::reg_idx_t         o_rs2,
    input  rv_exec_pkg::xlen_t            i_rs1_data,
    input  rv_exec_pkg::xlen_t            i_rs2_data,
    input  logic                          i_wb_we,
    input  rv_exec_pkg::reg_idx_t         i_wb_rd,
    input  rv_exec_pkg::xlen_t            i_wb_data,
    rv_retire_if.snoop                    i_fwd,
    rv_issue_if.src                       o_issue
);

    logic [6:0]             opcode;
    rv_exec_pkg::funct3_t   funct3;
    logic                   funct7_b5;
    rv_exec_pkg::op_class_e op_class;
    rv_exec_pkg::xlen_t     imm;
    rv_exec_pkg::xlen_t     pc_ext;
    rv_exec_pkg::xlen_t     rs1_val;
    rv_exec_pkg::xlen_t     rs2_val;
    rv_exec_pkg::xlen_t     target_sum;
    rv_exec_pkg::alu_ctrl_t ctrl;
    rv_exec_pkg::alu_res_t  res;

    // Execute result first, then writeback, then the register file.
    function automatic rv_exec_pkg::xlen_t fwd(rv_exec_pkg::reg_idx_t idx,
                                               rv_exec_pkg::xlen_t rf_data);
        if (i_fwd.valid && (i_fwd.rd == idx) && (idx != '0))
            return i_fwd.result;
        else if (i_wb_we && (i_wb_rd == idx))
            return i_wb_data;
        else
            return rf_data;
    endfunction

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];
    assign o_rs1     = i_instr[19:15];
    assign o_rs2     = i_instr[24:20];
    assign pc_ext    = rv_exec_pkg::xlen_t'(i_pc);
    assign rs1_val   = fwd(o_rs1, i_rs1_data);
    assign rs2_val   = fwd(o_rs2, i_rs2_data);

    always_comb
    begin
        op_class = rv_exec_pkg::op_illegal;
        imm      = {{20{i_instr[31]}}, i_instr[31:20]};
        case (opcode)
            7'b0110011: op_class = rv_exec_pkg::op_alu;
            7'b0010011: op_class = rv_exec_pkg::op_alui;
            7'b1100111: op_class = rv_exec_pkg::op_jalr;
            7'b0110111,
            7'b0010111:
            begin
                op_class = opcode[5] ? rv_exec_pkg::op_lui : rv_exec_pkg::op_auipc;
                imm      = {i_instr[31:12], 12'b0};
            end
            7'b1100011:
            begin
                op_class = rv_exec_pkg::op_branch;
                imm      = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                            i_instr[30:25], i_instr[11:8], 1'b0};
            end
            7'b1101111:
            begin
                op_class = rv_exec_pkg::op_jal;
                imm      = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                            i_instr[20], i_instr[30:21], 1'b0};
            end
            7'b0100011:
            begin
                op_class = rv_exec_pkg::op_store;
                imm      = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            default: op_class = rv_exec_pkg::op_illegal;
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        res  = '0;
        case (op_class)
            rv_exec_pkg::op_alu,
            rv_exec_pkg::op_alui:
            begin
                case (funct3)
                    3'b000:
                    begin
                        // Only the register form can subtract.
                        ctrl.arith_sub = (op_class == rv_exec_pkg::op_alu) && funct7_b5;
                        ctrl.arith_add = !ctrl.arith_sub;
                        res.arith      = 1'b1;
                    end
                    3'b001: {ctrl.arith_shl, res.shift} = 2'b11;
                    3'b010: {ctrl.cmp_lts, res.cmp} = 2'b11;
                    3'b011: {ctrl.cmp_ltu, res.cmp} = 2'b11;
                    3'b100: {ctrl.bits_xor, res.bits} = 2'b11;
                    3'b101:
                    begin
                        ctrl.arith_shr          = 1'b1;
                        ctrl.shift_arithmetical = funct7_b5;
                        res.shift               = 1'b1;
                    end
                    3'b110: {ctrl.bits_or, res.bits} = 2'b11;
                    default: {ctrl.bits_and, res.bits} = 2'b11;
                endcase
            end
            rv_exec_pkg::op_branch:
            begin
                ctrl.cmp_eq       = !funct3[2];
                ctrl.cmp_lts      = (funct3[2:1] == 2'b10);
                ctrl.cmp_ltu      = (funct3[2:1] == 2'b11);
                ctrl.cmp_inversed = funct3[0];
                res.cmp           = 1'b1;
            end
            default: {ctrl.arith_add, res.arith} = 2'b11;
        endcase
    end

    // Jump and branch target, bit 0 cleared for jalr.
    assign target_sum = ((op_class == rv_exec_pkg::op_jalr) ? rs1_val : pc_ext) + imm;

    assign o_issue.valid       = i_valid && (op_class != rv_exec_pkg::op_illegal);
    assign o_issue.op1         = (op_class == rv_exec_pkg::op_lui)   ? '0 :
                                 (op_class == rv_exec_pkg::op_auipc) ? pc_ext : rs1_val;
    assign o_issue.op2         = ((op_class == rv_exec_pkg::op_alu) ||
                                  (op_class == rv_exec_pkg::op_branch)) ? rs2_val : imm;
    assign o_issue.reg_data2   = rs2_val;
    assign o_issue.ctrl        = ctrl;
    assign o_issue.res         = res;
    assign o_issue.op_class    = op_class;
    assign o_issue.rd          = i_instr[11:7];
    assign o_issue.pc          = i_pc;
    assign o_issue.pc_next     = i_pc + IADDR_SPACE_BITS'(4);
    assign o_issue.target      = {target_sum[IADDR_SPACE_BITS-1:1],
                                  target_sum[0] & (op_class != rv_exec_pkg::op_jalr)};
    assign o_issue.branch_pred = i_branch_pred;
    assign o_issue.pred_target = i_pred_target;
    assign o_issue.funct3      = funct3;

endmodule

//--- logic/rv_exec_pkg.sv
package rv_exec_pkg;

    parameter int IADDR_SPACE_BITS = 32;

    typedef logic [31:0]                 xlen_t;
    typedef logic [IADDR_SPACE_BITS-1:0] iaddr_t;
    typedef logic [4:0]                  reg_idx_t;
    typedef logic [2:0]                  funct3_t;

    typedef struct packed {
        logic arith_add;
        logic arith_sub;
        logic arith_shl;
        logic arith_shr;
        logic shift_arithmetical;
        logic bits_xor;
        logic bits_or;
        logic bits_and;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
    } alu_ctrl_t;

    // Result source of the execute stage.
    typedef struct packed {
        logic arith;
        logic cmp;
        logic bits;
        logic shift;
    } alu_res_t;

    // Nine classes need four bits.
    typedef enum logic [3:0] {
        op_alu,
        op_alui,
        op_lui,
        op_auipc,
        op_branch,
        op_jal,
        op_jalr,
        op_store,
        op_illegal
    } op_class_e;

endpackage

//--- logic/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top #(
    parameter int IADDR_SPACE_BITS  = $bits(rv_exec_pkg::iaddr_t),
    parameter bit BRANCH_PREDICTION = 1'b1
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_valid,
    input  logic [31:0]                   i_instr,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pc,
    input  logic                          i_branch_pred,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pred_target,
    output logic                          o_pc_select,
    output logic [IADDR_SPACE_BITS-1:0]   o_pc_target,
    output logic                          o_st_valid,
    output logic [31:0]                   o_st_addr,
    output logic [31:0]                   o_st_wdata,
    output logic [3:0]                    o_st_wsel,
    output logic                          o_wb_valid,
    output logic [4:0]                    o_wb_rd,
    output logic [31:0]                   o_wb_data
);

    rv_exec_pkg::reg_idx_t rs1;
    rv_exec_pkg::reg_idx_t rs2;
    rv_exec_pkg::xlen_t    rs1_data;
    rv_exec_pkg::xlen_t    rs2_data;
    logic                  wb_we;
    rv_exec_pkg::reg_idx_t wb_rd;
    rv_exec_pkg::xlen_t    wb_data;

    rv_issue_if #(.IADDR_SPACE_BITS(IADDR_SPACE_BITS)) issue_bus ();
    rv_retire_if retire_bus ();

    rv_decode #(
        .IADDR_SPACE_BITS (IADDR_SPACE_BITS)
    ) u_decode (
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_branch_pred (i_branch_pred),
        .i_pred_target (i_pred_target),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .i_wb_we       (wb_we),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .i_fwd         (retire_bus.snoop),
        .o_issue       (issue_bus.src)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (wb_we),
        .i_rd       (wb_rd),
        .i_wdata    (wb_data)
    );

    rv_alu #(
        .IADDR_SPACE_BITS  (IADDR_SPACE_BITS),
        .BRANCH_PREDICTION (BRANCH_PREDICTION)
    ) u_alu (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_issue     (issue_bus.dst),
        .o_pc_select (o_pc_select),
        .o_pc_target (o_pc_target),
        .o_st_valid  (o_st_valid),
        .o_st_addr   (o_st_addr),
        .o_st_wdata  (o_st_wdata),
        .o_st_wsel   (o_st_wsel),
        .o_retire    (retire_bus.src)
    );

    rv_writeback u_writeback (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_retire   (retire_bus.dst),
        .o_we       (wb_we),
        .o_rd       (wb_rd),
        .o_data     (wb_data),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  rv_exec_pkg::reg_idx_t i_rs1,
    input  rv_exec_pkg::reg_idx_t i_rs2,
    output rv_exec_pkg::xlen_t    o_rs1_data,
    output rv_exec_pkg::xlen_t    o_rs2_data,
    input  logic                  i_we,
    input  rv_exec_pkg::reg_idx_t i_rd,
    input  rv_exec_pkg::xlen_t    i_wdata
);

    // No storage for x0.
    rv_exec_pkg::xlen_t regs [31:1];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- logic/rv_stage_if.sv
`timescale 1ns/1ps

interface rv_issue_if #(
    parameter int IADDR_SPACE_BITS = 32
);
    logic                          valid;
    rv_exec_pkg::xlen_t            op1;
    rv_exec_pkg::xlen_t            op2;
    rv_exec_pkg::xlen_t            reg_data2;
    rv_exec_pkg::alu_ctrl_t        ctrl;
    rv_exec_pkg::alu_res_t         res;
    rv_exec_pkg::op_class_e        op_class;
    rv_exec_pkg::reg_idx_t         rd;
    logic [IADDR_SPACE_BITS-1:0]   pc;
    logic [IADDR_SPACE_BITS-1:0]   pc_next;
    logic [IADDR_SPACE_BITS-1:0]   target;
    logic                          branch_pred;
    logic [IADDR_SPACE_BITS-1:0]   pred_target;
    rv_exec_pkg::funct3_t          funct3;

    modport src (
        output valid, op1, op2, reg_data2, ctrl, res, op_class, rd,
        output pc, pc_next, target, branch_pred, pred_target, funct3
    );

    modport dst (
        input valid, op1, op2, reg_data2, ctrl, res, op_class, rd,
        input pc, pc_next, target, branch_pred, pred_target, funct3
    );
endinterface

interface rv_retire_if;
    logic                  valid;
    rv_exec_pkg::reg_idx_t rd;
    rv_exec_pkg::xlen_t    result;

    modport src (output valid, rd, result);
    modport dst (input valid, rd, result);
    // Forwarding tap for decode.
    modport snoop (input valid, rd, result);
endinterface

//--- logic/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    rv_retire_if.dst              i_retire,
    output logic                  o_we,
    output rv_exec_pkg::reg_idx_t o_rd,
    output rv_exec_pkg::xlen_t    o_data,
    output logic                  o_wb_valid,
    output rv_exec_pkg::reg_idx_t o_wb_rd,
    output rv_exec_pkg::xlen_t    o_wb_data
);

    logic                  valid;
    rv_exec_pkg::reg_idx_t rd;
    rv_exec_pkg::xlen_t    data;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            valid <= 1'b0;
        else
            valid <= i_retire.valid && !i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        rd   <= i_retire.rd;
        data <= i_retire.result;
    end

    // x0 still retires but never writes.
    assign o_we   = valid && (rd != '0);
    assign o_rd   = rd;
    assign o_data = data;

    assign o_wb_valid = valid;
    assign o_wb_rd    = rd;
    assign o_wb_data  = data;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator.

verilator --binary --timing -Wno-fatal -f rv_exec.f --top-module rv_exec_tb \
    -o rv_exec_sim \
    && ./obj_dir/rv_exec_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- rv_exec.f
logic/rv_exec_pkg.sv
logic/rv_stage_if.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_writeback.sv
logic/rv_exec_top.sv
bench/tb_clock_gen.sv
bench/rv_exec_tb.sv
